//--- vlog.f
hw/bottomPkg.sv
hw/opReceiver.sv
hw/regsBuses.sv
hw/incDec.sv
hw/bottomLeftLogic.sv
hw/bottomSequencer.sv
hw/resultSender.sv
hw/bottom.sv
sim/bottom_sva.sv
sim/bottomTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module bottomTb -f vlog.f -o simBottom
status=0
out=$(./obj_dir/simBottom 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	exit "$status"
fi
printf '%s\n' "$out" | grep -qx '>>> PASS'

//--- sim/bottomTb.sv
`timescale 1ns/1ps

module bottomTb;

	import bottomPkg::*;

	localparam logic [AddrW-1:0] ResetPc = 16'h0150;
	localparam int NumCmds = 108;	// Sum over all six tests
	localparam int WatchCycles = NumCmds * 20 + 200;

	logic CLK;
	logic rstN;
	logic cmdReq;
	logic cmdAck;
	bottomOp cmdOp;
	regSel cmdReg;
	pairSel cmdPair;
	logic cmdDec;
	logic [DataW-1:0] cmdData;
	logic [3:0] cmdMask;
	logic cmdKill;
	logic [4:0] bro;
	logic resReq;
	logic resAck;
	logic [AddrW-1:0] resData;
	logic [AddrW-1:0] addr;
	logic bq4;
	logic bq5;
	logic bq7;

	logic [31:0] lfsrState = 32'h8025;
	logic [DataW-1:0] shReg [8];	// Shadow B C D E H L A F
	logic [AddrW-1:0] shSp;
	logic [AddrW-1:0] shPc;

	logic [AddrW-1:0] expQ [$];
	string nameQ [$];
	logic [AddrW-1:0] gotQ [$];
	int delayQ [$];	// Sink ack delay per command
	int issued = 0;
	int gotCount = 0;
	int sinkDone = 0;
	int doneCount = 0;
	int checkCount = 0;
	int errCount = 0;
	int baseChecks = 0;
	int baseErrs = 0;
	int delayBits = 0;

	bottom #(
		.RESET_PC(ResetPc)
	) bottom_inst (
		.CLK(CLK),
		.rstN(rstN),
		.cmdReq(cmdReq),
		.cmdAck(cmdAck),
		.cmdOp(cmdOp),
		.cmdReg(cmdReg),
		.cmdPair(cmdPair),
		.cmdDec(cmdDec),
		.cmdData(cmdData),
		.cmdMask(cmdMask),
		.cmdKill(cmdKill),
		.bro(bro),
		.resReq(resReq),
		.resAck(resAck),
		.resData(resData),
		.addr(addr),
		.bq4(bq4),
		.bq5(bq5),
		.bq7(bq7)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] takeBits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [AddrW-1:0] pairValue(pairSel p);
		case (p)
			pairBC: return {shReg[regB], shReg[regC]};
			pairDE: return {shReg[regD], shReg[regE]};
			pairHL: return {shReg[regH], shReg[regL]};
			default: return shSp;
		endcase
	endfunction

	function automatic logic [AddrW-1:0] stepPair(pairSel p, logic dec);
		return dec ? pairValue(p) - 16'd1 : pairValue(p) + 16'd1;	// Wraps modulo 2^16
	endfunction

	function automatic logic [AddrW-1:0] refResult(bottomOp op, regSel r, pairSel p,
			logic dec, logic [DataW-1:0] data, logic [3:0] mask, logic kill, logic [4:0] broVal);
		logic [DataW-1:0] val;
		val = shReg[r];
		case (op)
			opWrite: return {8'h00, data};
			opRead: return {8'h00, val};
			opIncDec: return stepPair(p, dec);
			opAddr: return pairValue(p);	// Old value, step lands afterwards
			opRst: return 16'(broVal) * 16'd8;
			opOperand: begin
				if (kill) return '0;
				for (int i = 0; i < 4; i++) begin
					if (mask[i]) val[4 + i] = 1'b0;
				end
				return {8'h00, val};
			end
			default: return '0;
		endcase
	endfunction

	function automatic logic [2:0] refFlags(logic [DataW-1:0] a);
		return {a[4] & a[7], a[5] | a[6] | a[7], a[1] | a[2] | a[3]};	// bq7 bq5 bq4
	endfunction

	task automatic setPair(pairSel p, logic [AddrW-1:0] v);
		case (p)
			pairBC: begin
				shReg[regB] = v[15:8];
				shReg[regC] = v[7:0];
			end
			pairDE: begin
				shReg[regD] = v[15:8];
				shReg[regE] = v[7:0];
			end
			pairHL: begin
				shReg[regH] = v[15:8];
				shReg[regL] = v[7:0];
			end
			default: shSp = v;
		endcase
	endtask

	task automatic applyEffect(bottomOp op, regSel r, pairSel p, logic dec,
			logic [DataW-1:0] data, logic [4:0] broVal);
		case (op)
			opWrite: shReg[r] = data;
			opIncDec, opAddr: setPair(p, stepPair(p, dec));
			opRst: shPc = 16'(broVal) * 16'd8;
			default: ;
		endcase
	endtask

	task automatic checkWord(string name, logic [AddrW-1:0] expected, logic [AddrW-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			errCount++;
		end
	endtask

	task automatic checkFlags(string name, logic [2:0] expected, logic [2:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("[FAIL] %s expected %b actual %b", name, expected, actual);
			errCount++;
		end
	endtask

	// Called on a falling edge, returns on one
	task automatic runCmd(string name, bottomOp op, regSel r, pairSel p, logic dec,
			logic [DataW-1:0] data, logic [3:0] mask, logic kill, logic [4:0] broVal);
		int issuedBefore;
		issuedBefore = issued;
		cmdOp = op;
		cmdReg = r;
		cmdPair = p;
		cmdDec = dec;
		cmdData = data;
		cmdMask = mask;
		cmdKill = kill;
		if (op == opRst) bro = broVal;	// Held until the next restart
		expQ.push_back(refResult(op, r, p, dec, data, mask, kill, broVal));
		nameQ.push_back(name);
		delayQ.push_back(int'(takeBits(delayBits)));
		issued++;
		cmdReq = 1'b1;
		do @(negedge CLK); while (!cmdAck);
		if (sinkDone != issuedBefore) begin
			$display("ERROR: cmdAck rose for %s while an earlier result was unacknowledged", name);
			errCount++;
		end
		cmdReq = 1'b0;
		do @(negedge CLK); while (cmdAck);
		applyEffect(op, r, p, dec, data, broVal);
	endtask

	task automatic doWrite(string name, regSel r, logic [DataW-1:0] d);
		runCmd(name, opWrite, r, pairBC, 1'b0, d, 4'h0, 1'b0, 5'd0);
	endtask

	task automatic doRead(string name, regSel r);
		runCmd(name, opRead, r, pairBC, 1'b0, 8'h00, 4'h0, 1'b0, 5'd0);
	endtask

	// Address bus shows the old pair while the sequencer sits in sExec
	task automatic addrCmd(string name, pairSel p, logic dec);
		logic [AddrW-1:0] old;
		old = pairValue(p);
		runCmd(name, opAddr, regB, p, dec, 8'h00, 4'h0, 1'b0, 5'd0);
		checkWord({name, " bus"}, old, addr);
	endtask

	task automatic waitDone();
		while (doneCount < issued) @(negedge CLK);
	endtask

	task automatic incDecCheck(string name, pairSel p, logic [DataW-1:0] hi,
			logic [DataW-1:0] lo, logic dec);
		regSel hiR;
		regSel loR;
		hiR = regSel'({p, 1'b0});
		loR = regSel'({p, 1'b1});
		doWrite(name, hiR, hi);
		doWrite(name, loR, lo);
		runCmd(name, opIncDec, regB, p, dec, 8'h00, 4'h0, 1'b0, 5'd0);
		doRead(name, hiR);
		doRead(name, loR);
	endtask

	task automatic finishTest(string name);
		waitDone();
		$display("%-10s %0d checks, %0d errors", name, checkCount - baseChecks, errCount - baseErrs);
		baseChecks = checkCount;
		baseErrs = errCount;
	endtask

	// Sink side of the result handshake
	initial begin : sink
		int delay;
		forever begin
			@(negedge CLK);
			if (rstN && resReq && !resAck) begin
				gotQ.push_back(resData);
				gotCount++;
				delay = (delayQ.size() > 0) ? delayQ.pop_front() : 0;
				repeat (delay) @(negedge CLK);
				resAck = 1'b1;
				do @(negedge CLK); while (resReq);
				resAck = 1'b0;
				sinkDone++;
			end
		end
	end

	initial begin : compare
		logic [AddrW-1:0] got;
		forever begin
			@(posedge CLK);
			while (gotQ.size() > 0) begin
				got = gotQ.pop_front();
				if (expQ.size() == 0) begin
					$display("ERROR: result %h arrived with no command pending", got);
					errCount++;
				end else begin
					checkWord(nameQ.pop_front(), expQ.pop_front(), got);
				end
				doneCount++;
			end
		end
	end

	initial begin : watchdog
		repeat (WatchCycles) @(posedge CLK);
		$display("ERROR: timeout, the run did not finish within %0d cycles", WatchCycles);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		regSel r;
		for (int i = 0; i < 8; i++) begin
			shReg[i] = '0;
		end
		shSp = '0;
		shPc = ResetPc;
		rstN = 1'b0;
		cmdReq = 1'b0;
		cmdOp = opWrite;
		cmdReg = regB;
		cmdPair = pairBC;
		cmdDec = 1'b0;
		cmdData = '0;
		cmdMask = '0;
		cmdKill = 1'b0;
		bro = '0;
		resAck = 1'b0;
		repeat (5) @(negedge CLK);
		rstN = 1'b1;
		@(negedge CLK);

		for (int i = 0; i < 8; i++) begin
			doWrite("regRw write", regSel'(3'(i)), 8'(takeBits(8)));
			doRead("regRw read", regSel'(3'(i)));
			doRead("regRw other", regSel'(3'((i + 3) % 8)));	// Untouched or earlier value
		end
		finishTest("regRw");

		for (int i = 0; i < 3; i++) begin
			incDecCheck("incDec rand", pairSel'(2'(i)), 8'(takeBits(8)), 8'(takeBits(8)),
				1'(takeBits(1)));
		end
		incDecCheck("incDec FFFF", pairBC, 8'hFF, 8'hFF, 1'b0);
		incDecCheck("incDec 0000", pairDE, 8'h00, 8'h00, 1'b1);
		runCmd("incDec SP dec", opIncDec, regB, pairSP, 1'b1, 8'h00, 4'h0, 1'b0, 5'd0);
		runCmd("incDec SP inc", opIncDec, regB, pairSP, 1'b0, 8'h00, 4'h0, 1'b0, 5'd0);
		finishTest("incDec");

		doWrite("addr HL", regH, 8'(takeBits(8)));
		doWrite("addr HL", regL, 8'(takeBits(8)));
		addrCmd("addr HL inc", pairHL, 1'b0);
		doRead("addr HL inc H", regH);
		doRead("addr HL inc L", regL);
		addrCmd("addr HL dec", pairHL, 1'b1);
		doRead("addr HL dec H", regH);
		doRead("addr HL dec L", regL);
		addrCmd("addr SP inc", pairSP, 1'b0);
		addrCmd("addr SP dec", pairSP, 1'b1);
		addrCmd("addr SP peek", pairSP, 1'b0);
		finishTest("addr");

		for (int i = 0; i < 4; i++) begin
			runCmd("rst", opRst, regB, pairBC, 1'b0, 8'h00, 4'h0, 1'b0, 5'(takeBits(5)));
			waitDone();
			checkWord("rst pc on addr", shPc, addr);	// Idle bus shows PC
			doRead("rst keep", regSel'(3'(takeBits(3))));
			doRead("rst keep", regSel'(3'(takeBits(3))));
		end
		finishTest("rst");

		for (int i = 0; i < 8; i++) begin
			r = regSel'(3'(takeBits(3)));
			doWrite("operand load", r, 8'(takeBits(8)));
			runCmd("operand", opOperand, r, pairBC, 1'b0, 8'h00, 4'(takeBits(4)),
				takeBits(2) == 32'd0, 5'd0);
		end
		for (int i = 0; i < 6; i++) begin
			doWrite("flags load", regA, 8'(takeBits(8)));
			waitDone();
			checkFlags("flags", refFlags(shReg[regA]), {bq7, bq5, bq4});
		end
		finishTest("operand");

		delayBits = 3;	// Sink stalls 0 to 7 cycles
		for (int i = 0; i < 12; i++) begin
			if (i % 2 == 0) begin
				doWrite("backpr write", regSel'(3'(takeBits(3))), 8'(takeBits(8)));
			end else begin
				doRead("backpr read", regSel'(3'(takeBits(3))));
			end
		end
		finishTest("backpr");
		delayBits = 0;

		repeat (10) @(negedge CLK);	// Room for a repeated result to show up
		if (gotCount != issued || expQ.size() != 0) begin
			$display("ERROR: %0d commands issued but %0d results received", issued, gotCount);
			errCount++;
		end
		$display("Summary: %0d commands, %0d checks, %0d errors", issued, checkCount, errCount);
		if (errCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- sim/bottom_sva.sv
`timescale 1ns/1ps

module bottom_sva (
	input logic                        CLK,
	input logic                        rstN,
	input logic                        cmdReq,
	input logic                        cmdAck,
	input logic                        resReq,
	input logic                        resAck,
	input logic [bottomPkg::AddrW-1:0] resData
);

	// Ack answers a request seen on the edge before
	ackAfterReq: assert property (@(posedge CLK) disable iff (!rstN)
		$rose(cmdAck) |-> $past(cmdReq))
		else $error("cmdAck rose without a preceding cmdReq");

	reqHold: assert property (@(posedge CLK) disable iff (!rstN)
		resReq && !resAck |=> resReq)	// No withdrawal before ack
		else $error("resReq dropped before resAck");

	dataStable: assert property (@(posedge CLK) disable iff (!rstN)
		resReq && $past(resReq) |-> $stable(resData))
		else $error("resData changed while resReq was high");

endmodule

bind bottom bottom_sva bottomSvaInst (
	.CLK(CLK),
	.rstN(rstN),
	.cmdReq(cmdReq),
	.cmdAck(cmdAck),
	.resReq(resReq),
	.resAck(resAck),
	.resData(resData)
);

//--- hw/bottom.sv
`timescale 1ns/1ps

module bottom #(
	parameter logic [bottomPkg::AddrW-1:0] RESET_PC = 16'h0000
) (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic                          cmdReq,
	output logic                          cmdAck,
	input  bottomPkg::bottomOp            cmdOp,
	input  bottomPkg::regSel              cmdReg,
	input  bottomPkg::pairSel             cmdPair,
	input  logic                          cmdDec,
	input  logic [bottomPkg::DataW-1:0]   cmdData,
	input  logic [3:0]                    cmdMask,
	input  logic                          cmdKill,
	input  logic [4:0]                    bro,
	output logic                          resReq,
	input  logic                          resAck,
	output logic [bottomPkg::AddrW-1:0]   resData,
	output logic [bottomPkg::AddrW-1:0]   addr,
	output logic                          bq4,
	output logic                          bq5,
	output logic                          bq7
);

	import bottomPkg::*;

	logic cmdValid;
	logic engineBusy;
	logic senderBusy;
	bottomOp opQ;
	regSel regQSel;
	pairSel pairQSel;
	logic decQ;
	logic [DataW-1:0] dataQ;
	logic [3:0] maskQ;
	logic killQ;

	logic regWe;
	regSel regWSel;
	logic [DataW-1:0] regWData;
	logic pairWe;
	pairSel pairWSel;
	logic [AddrW-1:0] pairWData;
	logic pcWe;
	logic [AddrW-1:0] pcWData;
	regSel regRSel;
	pairSel pairRSel;

	logic [DataW-1:0] regQ;
	logic [AddrW-1:0] pairQ;
	logic [AddrW-1:0] pcQ;
	logic [DataW-1:0] aQ;
	logic [AddrW-1:0] stepped;
	logic pairwise;
	logic [DataW-1:0] dv;
	logic resLoad;
	logic [AddrW-1:0] resValue;

	opReceiver receiver (
		.CLK(CLK),
		.rstN(rstN),
		.cmdReq(cmdReq),
		.cmdAck(cmdAck),
		.cmdOp(cmdOp),
		.cmdReg(cmdReg),
		.cmdPair(cmdPair),
		.cmdDec(cmdDec),
		.cmdData(cmdData),
		.cmdMask(cmdMask),
		.cmdKill(cmdKill),
		.engineBusy(engineBusy),
		.cmdValid(cmdValid),
		.opQ(opQ),
		.regQSel(regQSel),
		.pairQSel(pairQSel),
		.decQ(decQ),
		.dataQ(dataQ),
		.maskQ(maskQ),
		.killQ(killQ)
	);

	regsBuses #(
		.RESET_PC(RESET_PC)
	) regs (
		.CLK(CLK),
		.rstN(rstN),
		.regWe(regWe),
		.regWSel(regWSel),
		.regWData(regWData),
		.pairWe(pairWe),
		.pairWSel(pairWSel),
		.pairWData(pairWData),
		.pcWe(pcWe),
		.pcWData(pcWData),
		.regRSel(regRSel),
		.pairRSel(pairRSel),
		.regQ(regQ),
		.pairQ(pairQ),
		.pcQ(pcQ),
		.aQ(aQ)
	);

	incDec incdec (
		.value(pairQ),
		.dec(decQ),
		.pairwise(pairwise),
		.stepped(stepped)
	);

	bottomLeftLogic bottomLeft (
		.operand(regQ),
		.mask(maskQ),
		.kill(killQ),
		.aQ(aQ),
		.dv(dv),
		.bq4(bq4),
		.bq5(bq5),
		.bq7(bq7)
	);

	bottomSequencer sequencer (
		.CLK(CLK),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.opQ(opQ),
		.regQSel(regQSel),
		.pairQSel(pairQSel),
		.dataQ(dataQ),
		.regQ(regQ),
		.pairQ(pairQ),
		.pcQ(pcQ),
		.stepped(stepped),
		.dv(dv),
		.bro(bro),
		.senderBusy(senderBusy),
		.engineBusy(engineBusy),
		.regWe(regWe),
		.regWSel(regWSel),
		.regWData(regWData),
		.pairWe(pairWe),
		.pairWSel(pairWSel),
		.pairWData(pairWData),
		.pcWe(pcWe),
		.pcWData(pcWData),
		.regRSel(regRSel),
		.pairRSel(pairRSel),
		.pairwise(pairwise),
		.addr(addr),
		.resLoad(resLoad),
		.resValue(resValue)
	);

	resultSender sender (
		.CLK(CLK),
		.rstN(rstN),
		.resLoad(resLoad),
		.resValue(resValue),
		.resReq(resReq),
		.resAck(resAck),
		.resData(resData),
		.senderBusy(senderBusy)
	);

endmodule

//--- hw/resultSender.sv
`timescale 1ns/1ps

module resultSender (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic                        resLoad,
	input  logic [bottomPkg::AddrW-1:0] resValue,
	output logic                        resReq,
	input  logic                        resAck,
	output logic [bottomPkg::AddrW-1:0] resData,
	output logic                        senderBusy
);

	import bottomPkg::*;

	typedef enum logic [1:0] {
		txIdle = 2'd0,
		txReq  = 2'd1,
		txWait = 2'd2
	} txState;

	txState state;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= txIdle;
		end else begin
			case (state)
				txIdle: if (resLoad) state <= txReq;
				txReq: if (resAck) state <= txWait;	// Sink took the word
				txWait: if (!resAck) state <= txIdle;
				default: state <= txIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (resLoad && state == txIdle) resData <= resValue;
	end

	assign resReq = (state == txReq);
	assign senderBusy = (state != txIdle);

endmodule

//--- hw/bottomSequencer.sv
`timescale 1ns/1ps

module bottomSequencer (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic                          cmdValid,
	input  bottomPkg::bottomOp            opQ,
	input  bottomPkg::regSel              regQSel,
	input  bottomPkg::pairSel             pairQSel,
	input  logic [bottomPkg::DataW-1:0]   dataQ,
	input  logic [bottomPkg::DataW-1:0]   regQ,
	input  logic [bottomPkg::AddrW-1:0]   pairQ,
	input  logic [bottomPkg::AddrW-1:0]   pcQ,
	input  logic [bottomPkg::AddrW-1:0]   stepped,
	input  logic [bottomPkg::DataW-1:0]   dv,
	input  logic [4:0]                    bro,
	input  logic                          senderBusy,
	output logic                          engineBusy,
	output logic                          regWe,
	output bottomPkg::regSel              regWSel,
	output logic [bottomPkg::DataW-1:0]   regWData,
	output logic                          pairWe,
	output bottomPkg::pairSel             pairWSel,
	output logic [bottomPkg::AddrW-1:0]   pairWData,
	output logic                          pcWe,
	output logic [bottomPkg::AddrW-1:0]   pcWData,
	output bottomPkg::regSel              regRSel,
	output bottomPkg::pairSel             pairRSel,
	output logic                          pairwise,
	output logic [bottomPkg::AddrW-1:0]   addr,
	output logic                          resLoad,
	output logic [bottomPkg::AddrW-1:0]   resValue
);

	import bottomPkg::*;

	seqState state;
	seqState stateNext;
	logic [AddrW-1:0] vector;
	logic addrPhase;

	assign vector = {{(AddrW-8){1'b0}}, bro, 3'b000};	// Restart address, bro * 8
	assign addrPhase = (opQ == opAddr) && (state == sExec || state == sPost);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) state <= sIdle;
		else state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		case (state)
			sIdle: if (cmdValid) stateNext = sExec;
			sExec: stateNext = (opQ == opAddr) ? sPost : sSend;
			sPost: stateNext = sSend;
			sSend: if (!senderBusy) stateNext = sIdle;	// Result fully handed off
			default: stateNext = sIdle;
		endcase
	end

	always_comb begin
		regWe = 1'b0;
		pairWe = 1'b0;
		pcWe = 1'b0;
		resLoad = 1'b0;
		resValue = '0;
		case (state)
			sExec: begin
				resLoad = (opQ != opAddr);	// opAddr reports from sPost
				case (opQ)
					opWrite: begin
						regWe = 1'b1;
						resValue = {{(AddrW-DataW){1'b0}}, dataQ};
					end
					opRead: resValue = {{(AddrW-DataW){1'b0}}, regQ};
					opIncDec: begin
						pairWe = 1'b1;
						resValue = stepped;
					end
					opRst: begin
						pcWe = 1'b1;
						resValue = vector;
					end
					opOperand: resValue = {{(AddrW-DataW){1'b0}}, dv};
					default: resValue = '0;
				endcase
			end
			sPost: begin
				pairWe = 1'b1;	// Post increment or decrement
				resLoad = 1'b1;
				resValue = pairQ;	// Old value, write lands at cycle end
			end
			default: ;
		endcase
	end

	assign regWSel = regQSel;
	assign regWData = dataQ;
	assign pairWSel = pairQSel;
	assign pairWData = stepped;
	assign pcWData = vector;
	assign regRSel = regQSel;
	assign pairRSel = pairQSel;
	assign pairwise = (opQ == opRst);
	assign addr = addrPhase ? pairQ : pcQ;	// PC on the bus otherwise
	assign engineBusy = (state != sIdle) || senderBusy;

endmodule

//--- hw/bottomLeftLogic.sv
`timescale 1ns/1ps

module bottomLeftLogic (
	input  logic [bottomPkg::DataW-1:0] operand,
	input  logic [3:0]                  mask,
	input  logic                        kill,
	input  logic [bottomPkg::DataW-1:0] aQ,
	output logic [bottomPkg::DataW-1:0] dv,
	output logic                        bq4,
	output logic                        bq5,
	output logic                        bq7
);

	import bottomPkg::*;

	logic [3:0] hiNibble;

	// Per-bit clear of the high nibble for DAA corrections
	assign hiNibble = operand[7:4] & ~mask;

	always_comb begin
		if (kill) begin
			dv = '0;	// Operand forced to zero
		end else begin
			dv = {hiNibble, operand[3:0]};
		end
	end

	// Decimal adjust conditions from A
	assign bq4 = aQ[1] | aQ[2] | aQ[3];
	assign bq5 = aQ[5] | aQ[6] | aQ[7];
	assign bq7 = aQ[4] & aQ[7];

endmodule

//--- hw/incDec.sv
`timescale 1ns/1ps

module incDec (
	input  logic [bottomPkg::AddrW-1:0] value,
	input  logic                        dec,
	input  logic                        pairwise,
	output logic [bottomPkg::AddrW-1:0] stepped
);

	import bottomPkg::*;

	logic [AddrW-1:0] stepWord;
	logic [DataW-1:0] stepByte;
	logic [DataW-1:0] hiStepped;
	logic [DataW-1:0] loStepped;

	// Minus one is all ones, modulo width
	assign stepWord = dec ? {AddrW{1'b1}} : AddrW'(1);
	assign stepByte = dec ? {DataW{1'b1}} : DataW'(1);

	// Halves stepped on their own, no carry between them
	assign hiStepped = value[AddrW-1:DataW] + stepByte;
	assign loStepped = value[DataW-1:0] + stepByte;

	always_comb begin
		if (pairwise) begin
			stepped = {hiStepped, loStepped};
		end else begin
			stepped = value + stepWord;	// Full 16-bit carry chain
		end
	end

endmodule

//--- hw/regsBuses.sv
`timescale 1ns/1ps

module regsBuses #(
	parameter logic [bottomPkg::AddrW-1:0] RESET_PC = 16'h0000
) (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic                          regWe,
	input  bottomPkg::regSel              regWSel,
	input  logic [bottomPkg::DataW-1:0]   regWData,
	input  logic                          pairWe,
	input  bottomPkg::pairSel             pairWSel,
	input  logic [bottomPkg::AddrW-1:0]   pairWData,
	input  logic                          pcWe,
	input  logic [bottomPkg::AddrW-1:0]   pcWData,
	input  bottomPkg::regSel              regRSel,
	input  bottomPkg::pairSel             pairRSel,
	output logic [bottomPkg::DataW-1:0]   regQ,
	output logic [bottomPkg::AddrW-1:0]   pairQ,
	output logic [bottomPkg::AddrW-1:0]   pcQ,
	output logic [bottomPkg::DataW-1:0]   aQ
);

	import bottomPkg::*;

	logic [DataW-1:0] regs [8];	// B C D E H L A F
	logic [AddrW-1:0] sp;
	logic [AddrW-1:0] pc;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			sp <= '0;
			pc <= RESET_PC;
		end else begin
			if (regWe) regs[regWSel] <= regWData;
			// Pair write comes last so it overrides a byte write
			if (pairWe) begin
				case (pairWSel)
					pairBC: begin
						regs[regB] <= pairWData[AddrW-1:DataW];
						regs[regC] <= pairWData[DataW-1:0];
					end
					pairDE: begin
						regs[regD] <= pairWData[AddrW-1:DataW];
						regs[regE] <= pairWData[DataW-1:0];
					end
					pairHL: begin
						regs[regH] <= pairWData[AddrW-1:DataW];
						regs[regL] <= pairWData[DataW-1:0];
					end
					default: sp <= pairWData;
				endcase
			end
			if (pcWe) pc <= pcWData;
		end
	end

	always_comb begin
		case (pairRSel)
			pairBC: pairQ = {regs[regB], regs[regC]};
			pairDE: pairQ = {regs[regD], regs[regE]};
			pairHL: pairQ = {regs[regH], regs[regL]};
			default: pairQ = sp;
		endcase
	end

	assign regQ = regs[regRSel];
	assign aQ = regs[regA];	// Feeds decimal adjust flags
	assign pcQ = pc;

endmodule

//--- hw/opReceiver.sv
`timescale 1ns/1ps

module opReceiver (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic                          cmdReq,
	output logic                          cmdAck,
	input  bottomPkg::bottomOp            cmdOp,
	input  bottomPkg::regSel              cmdReg,
	input  bottomPkg::pairSel             cmdPair,
	input  logic                          cmdDec,
	input  logic [bottomPkg::DataW-1:0]   cmdData,
	input  logic [3:0]                    cmdMask,
	input  logic                          cmdKill,
	input  logic                          engineBusy,
	output logic                          cmdValid,
	output bottomPkg::bottomOp            opQ,
	output bottomPkg::regSel              regQSel,
	output bottomPkg::pairSel             pairQSel,
	output logic                          decQ,
	output logic [bottomPkg::DataW-1:0]   dataQ,
	output logic [3:0]                    maskQ,
	output logic                          killQ
);

	import bottomPkg::*;

	typedef enum logic {
		rxIdle = 1'b0,
		rxAck  = 1'b1
	} rxState;

	rxState state;
	logic accept;

	assign accept = (state == rxIdle) && cmdReq && !engineBusy;	// One command in flight
	assign cmdAck = (state == rxAck);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= rxIdle;
			cmdValid <= 1'b0;
		end else begin
			cmdValid <= accept;	// Single cycle pulse
			case (state)
				rxIdle: if (accept) state <= rxAck;
				rxAck: if (!cmdReq) state <= rxIdle;	// Wait for source to drop req
				default: state <= rxIdle;
			endcase
		end
	end

	// Command fields, captured once per request
	always_ff @(posedge CLK) begin
		if (accept) begin
			opQ <= cmdOp;
			regQSel <= cmdReg;
			pairQSel <= cmdPair;
			decQ <= cmdDec;
			dataQ <= cmdData;
			maskQ <= cmdMask;
			killQ <= cmdKill;
		end
	end

endmodule

//--- hw/bottomPkg.sv
package bottomPkg;

	parameter int DataW = 8;	// Byte width
	parameter int AddrW = 16;	// Address and pair width

	// Byte register index, order matches the register file array
	typedef enum logic [2:0] {
		regB = 3'd0,
		regC = 3'd1,
		regD = 3'd2,
		regE = 3'd3,
		regH = 3'd4,
		regL = 3'd5,
		regA = 3'd6,
		regF = 3'd7
	} regSel;

	typedef enum logic [1:0] {
		pairBC = 2'd0,
		pairDE = 2'd1,
		pairHL = 2'd2,
		pairSP = 2'd3
	} pairSel;

	typedef enum logic [2:0] {
		opWrite   = 3'd0,
		opRead    = 3'd1,
		opIncDec  = 3'd2,
		opAddr    = 3'd3,
		opRst     = 3'd4,
		opOperand = 3'd5
	} bottomOp;

	typedef enum logic [1:0] {
		sIdle = 2'd0,
		sExec = 2'd1,
		sPost = 2'd2,
		sSend = 2'd3
	} seqState;

endpackage
